// ==== ccl_label_pkg.sv ====
`default_nettype none

// label encoding for the labeller datapath
package ccl_label_pkg;

	localparam int LABEL_BITS = 4;

	// region label, zero is background
	typedef logic [LABEL_BITS-1:0] label_t;

	// allocation stops here, later objects share it
	localparam label_t LABEL_MAX = label_t'(15);

	// label reported on the binary mask output
	localparam label_t BIN_LABEL = label_t'(1);

endpackage

`default_nettype wire

// ==== ccl_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module ccl_top (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   href_in,
	input  wire                   vsync_in,
	input  wire                   de_in,
	input  wire                   pixel_in,
	output logic                  href_out,
	output logic                  vsync_out,
	output logic                  de_out,
	output ccl_label_pkg::label_t label_out,
	output logic                  bin_out
);

	import ccl_video_pkg::*;
	import ccl_label_pkg::*;

	// stage one pixel and strobes
	logic   pix_valid;
	logic   pix_fg;
	x_t     x_pos;
	logic   frame_start;
	logic   line_end;
	// row above around the current column
	label_t up_left;
	label_t up;
	label_t up_right;
	// current row write back
	logic   wr_en;
	x_t     wr_x;
	label_t wr_label;

	video_timing timing_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.href_in     (href_in),
		.vsync_in    (vsync_in),
		.de_in       (de_in),
		.pixel_in    (pixel_in),
		.pix_valid   (pix_valid),
		.pix_fg      (pix_fg),
		.x_pos       (x_pos),
		.frame_start (frame_start),
		.line_end    (line_end),
		.href_out    (href_out),
		.vsync_out   (vsync_out),
		.de_out      (de_out)
	);

	label_line_buffer line_buf_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.line_end    (line_end),
		.x_pos       (x_pos),
		.wr_en       (wr_en),
		.wr_x        (wr_x),
		.wr_label    (wr_label),
		.up_left     (up_left),
		.up          (up),
		.up_right    (up_right)
	);

	label_assign assign_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.pix_valid   (pix_valid),
		.pix_fg      (pix_fg),
		.x_pos       (x_pos),
		.frame_start (frame_start),
		.line_end    (line_end),
		.up_left     (up_left),
		.up          (up),
		.up_right    (up_right),
		.wr_en       (wr_en),
		.wr_x        (wr_x),
		.wr_label    (wr_label),
		.label_out   (label_out),
		.bin_out     (bin_out)
	);

endmodule

`default_nettype wire

// ==== ccl_video_pkg.sv ====
`default_nettype none

// frame geometry shared by the timing and line buffer blocks
package ccl_video_pkg;

	// pixels per line, kept small for short runs
	localparam int IMG_WIDTH = 16;

	// one spare bit over the row index
	// so the counter can step past the last column
	localparam int X_BITS = 5;

	// column position of a pixel
	typedef logic [X_BITS-1:0] x_t;

endpackage

`default_nettype wire

// ==== compile.f ====
ccl_video_pkg.sv
ccl_label_pkg.sv
video_timing.sv
label_line_buffer.sv
label_assign.sv
ccl_top.sv
tb_ccl_top.sv

// ==== label_assign.sv ====
`default_nettype none
`timescale 1ns/1ps

module label_assign (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        pix_valid,
	input  wire                        pix_fg,
	input  wire ccl_video_pkg::x_t     x_pos,
	input  wire                        frame_start,
	input  wire                        line_end,
	input  wire ccl_label_pkg::label_t up_left,
	input  wire ccl_label_pkg::label_t up,
	input  wire ccl_label_pkg::label_t up_right,
	output logic                       wr_en,
	output ccl_video_pkg::x_t          wr_x,
	output ccl_label_pkg::label_t      wr_label,
	output ccl_label_pkg::label_t      label_out,
	output logic                       bin_out
);

	import ccl_video_pkg::*;
	import ccl_label_pkg::*;

	label_t left_lbl;
	label_t alloc_cnt;
	label_t next_lbl;
	label_t nb_min;
	label_t pix_label;
	logic   new_obj;
	x_t     cur_x;

	// smaller of two labels, background ignored
	function automatic label_t min_nz(input label_t a, input label_t b);
		if (a == '0)
			return b;
		else if (b == '0)
			return a;
		else
			return (a < b) ? a : b;
	endfunction

	// counter holds at the top label once used up
	assign next_lbl = (alloc_cnt == LABEL_MAX) ? LABEL_MAX : alloc_cnt + label_t'(1);

	always_comb
	begin
		nb_min = min_nz(min_nz(left_lbl, up_left), min_nz(up, up_right));
		if (!pix_fg)
			pix_label = '0;
		else if (nb_min != '0)
			pix_label = nb_min;
		else
			pix_label = next_lbl;
	end

	// all four neighbours empty, so a new object starts here
	assign new_obj = pix_valid && pix_fg && (nb_min == '0);

	// current row written in the same cycle, background too
	assign cur_x    = x_pos;
	assign wr_en    = pix_valid;
	assign wr_x     = cur_x;
	assign wr_label = pix_label;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			alloc_cnt <= '0;
		else if (frame_start)
			alloc_cnt <= '0;
		else if (new_obj)
			alloc_cnt <= next_lbl;
	end

	// left neighbour, nothing to the left of column zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			left_lbl <= '0;
		else if (frame_start || line_end)
			left_lbl <= '0;
		else if (pix_valid)
			left_lbl <= pix_label;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			label_out <= '0;
			bin_out   <= 1'b0;
		end
		else if (pix_valid)
		begin
			label_out <= pix_label;
			bin_out   <= (pix_label == BIN_LABEL);
		end
		else
		begin
			// gaps in de give background on the output
			label_out <= '0;
			bin_out   <= 1'b0;
		end
	end

	// no label is handed out before the counter reaches it
	a_label_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		label_out <= alloc_cnt
	);

	// mask only ever marks labelled pixels
	a_bin_fg: assert property (
		@(posedge clk) disable iff (!rst_n)
		bin_out |-> (label_out != '0)
	);

endmodule

`default_nettype wire

// ==== label_line_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module label_line_buffer (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    frame_start,
	input  wire                    line_end,
	input  wire ccl_video_pkg::x_t x_pos,
	input  wire                    wr_en,
	input  wire ccl_video_pkg::x_t wr_x,
	input  wire ccl_label_pkg::label_t wr_label,
	output ccl_label_pkg::label_t  up_left,
	output ccl_label_pkg::label_t  up,
	output ccl_label_pkg::label_t  up_right
);

	import ccl_video_pkg::*;
	import ccl_label_pkg::*;

	label_t cur_row   [IMG_WIDTH];
	label_t above_row [IMG_WIDTH];

	// row index drops the spare counter bit
	logic [X_BITS-2:0] idx_mid;
	logic [X_BITS-2:0] idx_left;
	logic [X_BITS-2:0] idx_right;
	logic [X_BITS-2:0] idx_wr;
	logic              has_left;
	logic              has_mid;
	logic              has_right;

	assign idx_mid   = x_pos[X_BITS-2:0];
	assign idx_left  = idx_mid - (X_BITS-1)'(1);
	assign idx_right = idx_mid + (X_BITS-1)'(1);
	assign idx_wr    = wr_x[X_BITS-2:0];

	// neighbours off either end of the row read as background
	assign has_mid   = x_pos < x_t'(IMG_WIDTH);
	assign has_left  = has_mid && (x_pos != '0);
	assign has_right = x_pos < x_t'(IMG_WIDTH - 1);

	assign up_left  = has_left  ? above_row[idx_left]  : '0;
	assign up       = has_mid   ? above_row[idx_mid]   : '0;
	assign up_right = has_right ? above_row[idx_right] : '0;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < IMG_WIDTH; i++)
			begin
				cur_row[i]   <= '0;
				above_row[i] <= '0;
			end
		end
		else if (frame_start || line_end)
		begin
			// finished row moves up, fresh row starts empty
			// a new frame empties both rows
			for (int i = 0; i < IMG_WIDTH; i++)
			begin
				above_row[i] <= frame_start ? '0 : cur_row[i];
				cur_row[i]   <= '0;
			end
		end
		else if (wr_en)
			cur_row[idx_wr] <= wr_label;
	end

	// lines longer than the buffer would wrap onto column zero
	a_wr_in_row: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_x < x_t'(IMG_WIDTH))
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the labeller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module tb_ccl_top -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_ccl_top)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
	exit 0
else
	exit 1
fi

// ==== tb_ccl_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_ccl_top;

	import ccl_video_pkg::*;
	import ccl_label_pkg::*;

	localparam int MAX_ROWS   = 8;
	localparam int N_FRAMES   = 11;
	localparam int CLK_NS     = 8;
	// every frame counted as the tallest one, doubled for margin
	localparam int TIMEOUT_NS = N_FRAMES * (MAX_ROWS * (IMG_WIDTH + 4)) * CLK_NS * 2;

	// what the outputs must show two cycles after a drive
	typedef struct packed {
		logic   href;
		logic   vsync;
		logic   de;
		logic   bin;
		label_t lbl;
	} exp_t;

	logic   clk;
	logic   rst_n;
	logic   href_in;
	logic   vsync_in;
	logic   de_in;
	logic   pixel_in;
	logic   href_out;
	logic   vsync_out;
	logic   de_out;
	label_t label_out;
	logic   bin_out;

	logic   frame   [MAX_ROWS][IMG_WIDTH];
	label_t exp_lbl [MAX_ROWS][IMG_WIDTH];
	exp_t   exp_q[$];
	string  test_name;
	int     n_checks;
	int     n_errors;
	int     test_first_err;
	logic [31:0] rnd;

	ccl_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.href_in   (href_in),
		.vsync_in  (vsync_in),
		.de_in     (de_in),
		.pixel_in  (pixel_in),
		.href_out  (href_out),
		.vsync_out (vsync_out),
		.de_out    (de_out),
		.label_out (label_out),
		.bin_out   (bin_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the stimulus never finished", TIMEOUT_NS);
		$display("Result: FAILED");
		$finish;
	end

	task automatic check_label(input string name, input label_t exp, input label_t act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// one clock of stimulus, outputs checked against the entry from two cycles back
	task automatic drive_cycle(input logic h, input logic v, input logic d, input logic p,
		input label_t lbl);
		exp_t e;
		exp_t old;
		@(posedge clk);
		href_in  <= h;
		vsync_in <= v;
		de_in    <= d;
		pixel_in <= p;
		e.href  = h;
		e.vsync = v;
		e.de    = d;
		// no valid pixel means background on the output
		e.lbl   = d ? lbl : '0;
		e.bin   = d && (lbl == BIN_LABEL);
		exp_q.push_back(e);
		@(negedge clk);
		old = exp_q.pop_front();
		check_bit({test_name, " href_out"}, old.href, href_out);
		check_bit({test_name, " vsync_out"}, old.vsync, vsync_out);
		check_bit({test_name, " de_out"}, old.de, de_out);
		check_label({test_name, " label_out"}, old.lbl, label_out);
		check_bit({test_name, " bin_out"}, old.bin, bin_out);
	endtask

	function automatic label_t model_at(input int r, input int c);
		if (r < 0 || c < 0 || c >= IMG_WIDTH)
			return '0;
		return exp_lbl[r][c];
	endfunction

	// scan order labelling, smallest labelled neighbour wins, no merging
	function automatic void label_model(input int rows);
		int     next_id;
		label_t best;
		label_t nbs [4];
		next_id = 0;
		for (int r = 0; r < rows; r++)
		begin
			for (int c = 0; c < IMG_WIDTH; c++)
			begin
				// left, up-left, up, up-right
				nbs[0] = model_at(r, c - 1);
				nbs[1] = model_at(r - 1, c - 1);
				nbs[2] = model_at(r - 1, c);
				nbs[3] = model_at(r - 1, c + 1);
				best = '0;
				for (int k = 0; k < 4; k++)
					if (nbs[k] != '0 && (best == '0 || nbs[k] < best))
						best = nbs[k];
				if (!frame[r][c])
					exp_lbl[r][c] = '0;
				else if (best != '0)
					exp_lbl[r][c] = best;
				else
				begin
					if (next_id < 15)
						next_id++;
					exp_lbl[r][c] = label_t'(next_id);
				end
			end
		end
	endfunction

	function automatic void clear_frame();
		for (int r = 0; r < MAX_ROWS; r++)
			for (int c = 0; c < IMG_WIDTH; c++)
				frame[r][c] = 1'b0;
	endfunction

	task automatic send_frame(input int rows);
		label_model(rows);
		// vsync pulse then one quiet cycle
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0);
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0);
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		for (int r = 0; r < rows; r++)
		begin
			for (int c = 0; c < IMG_WIDTH; c++)
				drive_cycle(1'b1, 1'b0, 1'b1, frame[r][c], exp_lbl[r][c]);
			// blanking between lines
			drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
			drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		end
	endtask

	task automatic start_test(input string name);
		test_name      = name;
		test_first_err = n_errors;
	endtask

	task automatic finish_test();
		if (n_errors == test_first_err)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, n_errors - test_first_err);
	endtask

	task automatic test_reset();
		start_test("reset");
		@(negedge clk);
		check_bit("reset href_out", 1'b0, href_out);
		check_bit("reset vsync_out", 1'b0, vsync_out);
		check_bit("reset de_out", 1'b0, de_out);
		check_bit("reset bin_out", 1'b0, bin_out);
		check_label("reset label_out", '0, label_out);
		repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		finish_test();
	endtask

	task automatic test_sync_delay();
		start_test("sync_delay");
		clear_frame();
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < IMG_WIDTH; c++)
				frame[r][c] = ((r + c) % 3) == 0;
		send_frame(4);
		finish_test();
	endtask

	task automatic test_separate_blobs();
		start_test("separate_blobs");
		clear_frame();
		// three two-pixel blobs, expect 1, 2, 3 left to right
		frame[0][1]  = 1'b1;
		frame[0][2]  = 1'b1;
		frame[0][5]  = 1'b1;
		frame[0][6]  = 1'b1;
		frame[0][10] = 1'b1;
		frame[0][11] = 1'b1;
		send_frame(2);
		finish_test();
	endtask

	task automatic test_neighbour_rule();
		start_test("neighbour_diagonal");
		clear_frame();
		// one chain going down-left, one going down-right
		for (int r = 0; r < 4; r++)
		begin
			frame[r][6 - r]  = 1'b1;
			frame[r][10 + r] = 1'b1;
		end
		send_frame(4);
		finish_test();
		start_test("neighbour_v_shape");
		clear_frame();
		// arms meet at the bottom point
		for (int r = 0; r < 4; r++)
		begin
			frame[r][2 + r] = 1'b1;
			frame[r][8 - r] = 1'b1;
		end
		send_frame(4);
		finish_test();
		start_test("neighbour_u_shape");
		clear_frame();
		for (int r = 0; r < 3; r++)
		begin
			frame[r][1] = 1'b1;
			frame[r][5] = 1'b1;
		end
		for (int c = 1; c <= 5; c++)
			frame[3][c] = 1'b1;
		send_frame(4);
		finish_test();
	endtask

	task automatic test_saturation();
		start_test("saturation");
		clear_frame();
		// 24 isolated dots, the counter runs out at the fifteenth
		for (int r = 0; r < 5; r += 2)
			for (int c = 0; c < IMG_WIDTH; c += 2)
				frame[r][c] = 1'b1;
		send_frame(5);
		finish_test();
		start_test("restart");
		clear_frame();
		frame[1][3] = 1'b1;
		send_frame(3);
		finish_test();
	endtask

	task automatic test_random_frames();
		for (int f = 0; f < 4; f++)
		begin
			start_test($sformatf("random_%0d", f));
			clear_frame();
			for (int r = 0; r < MAX_ROWS; r++)
			begin
				for (int c = 0; c < IMG_WIDTH; c++)
				begin
					rnd = $urandom;
					frame[r][c] = rnd[0];
				end
			end
			send_frame(MAX_ROWS);
			finish_test();
		end
	endtask

	initial
	begin
		rnd      = $urandom(40716);
		n_checks = 0;
		n_errors = 0;
		rst_n    = 1'b0;
		// inputs busy during reset, only the reset keeps the outputs at zero
		href_in  = 1'b1;
		vsync_in = 1'b1;
		de_in    = 1'b1;
		pixel_in = 1'b1;
		repeat (3) @(posedge clk);
		rst_n    <= 1'b1;
		href_in  <= 1'b0;
		vsync_in <= 1'b0;
		de_in    <= 1'b0;
		pixel_in <= 1'b0;
		// pipeline holds two idle cycles after reset
		exp_q.push_back('0);
		exp_q.push_back('0);
		test_reset();
		test_sync_delay();
		test_separate_blobs();
		test_neighbour_rule();
		test_saturation();
		test_random_frames();
		repeat (3) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== video_timing.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_timing (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               href_in,
	input  wire               vsync_in,
	input  wire               de_in,
	input  wire               pixel_in,
	output logic              pix_valid,
	output logic              pix_fg,
	output ccl_video_pkg::x_t x_pos,
	output logic              frame_start,
	output logic              line_end,
	output logic              href_out,
	output logic              vsync_out,
	output logic              de_out
);

	import ccl_video_pkg::*;

	// first tap, lines up with the pixel register
	logic href_d1;
	logic vsync_d1;
	logic de_d1;
	logic pixel_d1;
	// second tap, lines up with the label register
	logic href_d2;
	logic vsync_d2;
	logic de_d2;
	x_t   x_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			href_d1  <= 1'b0;
			vsync_d1 <= 1'b0;
			de_d1    <= 1'b0;
			pixel_d1 <= 1'b0;
			href_d2  <= 1'b0;
			vsync_d2 <= 1'b0;
			de_d2    <= 1'b0;
		end
		else
		begin
			href_d1  <= href_in;
			vsync_d1 <= vsync_in;
			de_d1    <= de_in;
			pixel_d1 <= pixel_in;
			href_d2  <= href_d1;
			vsync_d2 <= vsync_d1;
			de_d2    <= de_d1;
		end
	end

	// edges seen between the two taps
	assign frame_start = vsync_d1 & ~vsync_d2;
	assign line_end    = href_d2 & ~href_d1;

	// column of the pixel now in the first tap
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			x_cnt <= '0;
		else if (frame_start || line_end)
			x_cnt <= '0;
		else if (de_d1)
			x_cnt <= x_cnt + x_t'(1);
	end

	assign pix_valid = de_d1;
	assign pix_fg    = pixel_d1;
	assign x_pos     = x_cnt;

	// sync leaves two cycles late, same as the labels
	assign href_out  = href_d2;
	assign vsync_out = vsync_d2;
	assign de_out    = de_d2;

	// a frame must not open on the edge that closes a line
	a_strobe_clash: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(frame_start && line_end)
	);

endmodule

`default_nettype wire
